// File: Bender.yml
package:
  name: axi2axilite_rd

sources:
  - design/axi_bridge_pkg.sv
  - design/burst_info_if.sv
  - design/axi_skid_buffer.sv
  - design/burst_info_fifo.sv
  - design/ar_burst_splitter.sv
  - design/r_burst_merger.sv
  - design/axi2axilite_rd.sv
  - target: test
    files:
      - verif/tb_axi2axilite_rd.sv

// File: compile.f
design/axi_bridge_pkg.sv
design/burst_info_if.sv
design/axi_skid_buffer.sv
design/burst_info_fifo.sv
design/ar_burst_splitter.sv
design/r_burst_merger.sv
design/axi2axilite_rd.sv
verif/tb_axi2axilite_rd.sv

// File: design/ar_burst_splitter.sv
// AR burst splitter issuing one AXI-lite read address per burst beat
module ar_burst_splitter
	import axi_bridge_pkg::*;
#(
	parameter int ID_WIDTH   = 2,
	parameter int ADDR_WIDTH = 12
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,

	// Request from the AR skid buffer
	input  logic                  i_req_valid,
	output logic                  o_req_ready,
	input  logic [ID_WIDTH-1:0]   i_req_id,
	input  logic [ADDR_WIDTH-1:0] i_req_addr,
	input  burst_len_t            i_req_len,
	input  burst_size_t           i_req_size,
	input  burst_type_t           i_req_burst,

	// AXI-lite read address
	output logic                  o_m_arvalid,
	input  logic                  i_m_arready,
	output logic [ADDR_WIDTH-1:0] o_m_araddr,

	burst_info_if.splitter        info
);

	logic                  r_arvalid;
	burst_len_t            r_remain;
	logic [ADDR_WIDTH-1:0] r_addr;
	burst_size_t           r_size;
	burst_type_t           r_burst;
	logic [ADDR_WIDTH-1:0] addr_step;
	logic [ADDR_WIDTH-1:0] next_addr;
	logic                  req_accept;
	logic                  beat_done;

	assign beat_done = r_arvalid && i_m_arready;

	// Idle, or last beat leaving this cycle, and room for the burst info
	assign o_req_ready = (!r_arvalid || (beat_done && r_remain == '0)) && !info.full;
	assign req_accept  = i_req_valid && o_req_ready;

	//////////////////////////////
	// Next beat address
	//////////////////////////////

	// WRAP bursts step like INCR
	always_comb
	begin
		addr_step = {{(ADDR_WIDTH-1){1'b0}}, 1'b1} << r_size;
		if (r_burst == BURST_FIXED)
			next_addr = r_addr;
		else
			next_addr = r_addr + addr_step;
	end

	//////////////////////////////
	// Beat sequencing
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_arvalid <= 1'b0;
			r_remain  <= '0;
		end
		else if (req_accept)
		begin
			r_arvalid <= 1'b1;
			r_remain  <= i_req_len;
		end
		else if (beat_done)
		begin
			if (r_remain == '0)
				r_arvalid <= 1'b0;
			else
				r_remain <= r_remain - 1'b1;
		end
	end

	// Address and burst shape held through a stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (req_accept)
		begin
			r_addr  <= i_req_addr;
			r_size  <= i_req_size;
			r_burst <= i_req_burst;
		end
		else if (beat_done)
		begin
			r_addr <= next_addr;
		end
	end

	assign o_m_arvalid = r_arvalid;
	assign o_m_araddr  = r_addr;

	// One FIFO entry per accepted burst
	assign info.push     = req_accept;
	assign info.push_id  = i_req_id;
	assign info.push_len = i_req_len;

endmodule

// File: design/axi2axilite_rd.sv
// AXI to AXI-lite read bridge splitting read bursts into single-beat reads
module axi2axilite_rd
	import axi_bridge_pkg::*;
#(
	parameter int ID_WIDTH      = 2,
	parameter int ADDR_WIDTH    = 12,
	parameter int DATA_WIDTH    = 32,
	parameter int LG_FIFO_DEPTH = 4
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,

	// AXI slave read address
	input  logic                  i_s_arvalid,
	output logic                  o_s_arready,
	input  logic [ID_WIDTH-1:0]   i_s_arid,
	input  logic [ADDR_WIDTH-1:0] i_s_araddr,
	input  burst_len_t            i_s_arlen,
	input  burst_size_t           i_s_arsize,
	input  burst_type_t           i_s_arburst,

	// AXI slave read data
	output logic                  o_s_rvalid,
	input  logic                  i_s_rready,
	output logic [ID_WIDTH-1:0]   o_s_rid,
	output logic [DATA_WIDTH-1:0] o_s_rdata,
	output axi_resp_t             o_s_rresp,
	output logic                  o_s_rlast,

	// AXI-lite master read
	output logic                  o_m_arvalid,
	input  logic                  i_m_arready,
	output logic [ADDR_WIDTH-1:0] o_m_araddr,
	input  logic                  i_m_rvalid,
	output logic                  o_m_rready,
	input  logic [DATA_WIDTH-1:0] i_m_rdata,
	input  axi_resp_t             i_m_rresp
);

	typedef struct packed
	{
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
		burst_len_t            len;
		burst_size_t           size;
		burst_type_t           burst;
	} ar_req_t;

	typedef struct packed
	{
		logic [DATA_WIDTH-1:0] data;
		axi_resp_t             resp;
	} r_beat_t;

	ar_req_t ar_in;
	ar_req_t ar_out;
	logic    ar_valid;
	logic    ar_ready;
	r_beat_t r_in;
	r_beat_t r_out;
	logic    r_valid;
	logic    r_ready;

	assign ar_in = '{id: i_s_arid, addr: i_s_araddr, len: i_s_arlen,
		size: i_s_arsize, burst: i_s_arburst};
	assign r_in  = '{data: i_m_rdata, resp: i_m_rresp};

	//////////////////////////////
	// Channel skid buffers
	//////////////////////////////

	axi_skid_buffer #(.payload_t(ar_req_t)) u_ar_skid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_s_arvalid),
		.o_ready       (o_s_arready),
		.i_data        (ar_in),
		.o_valid       (ar_valid),
		.i_ready       (ar_ready),
		.o_data        (ar_out)
	);

	axi_skid_buffer #(.payload_t(r_beat_t)) u_r_skid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_m_rvalid),
		.o_ready       (o_m_rready),
		.i_data        (r_in),
		.o_valid       (r_valid),
		.i_ready       (r_ready),
		.o_data        (r_out)
	);

	//////////////////////////////
	// Burst bookkeeping
	//////////////////////////////

	burst_info_if #(.ID_WIDTH(ID_WIDTH)) u_info ();

	burst_info_fifo #(
		.ID_WIDTH      (ID_WIDTH),
		.LG_FIFO_DEPTH (LG_FIFO_DEPTH)
	) u_fifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.bus           (u_info.fifo)
	);

	ar_burst_splitter #(
		.ID_WIDTH   (ID_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_splitter (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_req_valid   (ar_valid),
		.o_req_ready   (ar_ready),
		.i_req_id      (ar_out.id),
		.i_req_addr    (ar_out.addr),
		.i_req_len     (ar_out.len),
		.i_req_size    (ar_out.size),
		.i_req_burst   (ar_out.burst),
		.o_m_arvalid   (o_m_arvalid),
		.i_m_arready   (i_m_arready),
		.o_m_araddr    (o_m_araddr),
		.info          (u_info.splitter)
	);

	r_burst_merger #(
		.ID_WIDTH   (ID_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) u_merger (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_beat_valid  (r_valid),
		.o_beat_ready  (r_ready),
		.i_beat_data   (r_out.data),
		.i_beat_resp   (r_out.resp),
		.o_s_rvalid    (o_s_rvalid),
		.i_s_rready    (i_s_rready),
		.o_s_rid       (o_s_rid),
		.o_s_rdata     (o_s_rdata),
		.o_s_rresp     (o_s_rresp),
		.o_s_rlast     (o_s_rlast),
		.info          (u_info.merger)
	);

endmodule

// File: design/axi_bridge_pkg.sv
// AXI bridge package with the burst field types and response codes
package axi_bridge_pkg;

	//////////////////////////////
	// Burst request fields
	//////////////////////////////

	// Beats in the burst minus one
	typedef logic [7:0] burst_len_t;

	// Log2 of bytes per beat
	typedef logic [2:0] burst_size_t;

	typedef enum logic [1:0]
	{
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_type_t;

	//////////////////////////////
	// Response codes
	//////////////////////////////

	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_t;

endpackage

// File: design/axi_skid_buffer.sv
// Skid buffer for a valid/ready channel with a generic payload type
module axi_skid_buffer
#(
	parameter type payload_t = logic [7:0]
) (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,

	// Upstream side
	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,

	// Downstream side
	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);

	logic     r_valid;
	payload_t r_data;

	//////////////////////////////
	// Skid register control
	//////////////////////////////

	// Capture when an item arrives and the output stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_valid <= 1'b0;
		end
		else if (r_valid)
		begin
			// Held item leaves once downstream takes it
			if (i_ready)
			begin
				r_valid <= 1'b0;
			end
		end
		else if (i_valid && !i_ready)
		begin
			r_valid <= 1'b1;
		end
	end

	// Skid register payload
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!r_valid && i_valid && !i_ready)
		begin
			r_data <= i_data;
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// Full skid stage refuses new input until drained
	assign o_ready = !r_valid;

	// Straight through while the register is empty
	assign o_valid = r_valid || i_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

// File: design/burst_info_fifo.sv
// Burst info FIFO holding ID and length of each accepted read burst
module burst_info_fifo
	import axi_bridge_pkg::*;
#(
	parameter int ID_WIDTH      = 2,
	parameter int LG_FIFO_DEPTH = 4
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	burst_info_if.fifo    bus
);

	localparam int DEPTH = 1 << LG_FIFO_DEPTH;

	logic [ID_WIDTH-1:0]      mem_id [DEPTH];
	burst_len_t               mem_len [DEPTH];
	logic [LG_FIFO_DEPTH-1:0] r_wr_ptr;
	logic [LG_FIFO_DEPTH-1:0] r_rd_ptr;
	logic [LG_FIFO_DEPTH:0]   r_count;
	logic                     do_push;
	logic                     do_pop;

	assign do_push = bus.push && !bus.full;
	assign do_pop  = bus.pop && !bus.empty;

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_push)
		begin
			mem_id[r_wr_ptr]  <= bus.push_id;
			mem_len[r_wr_ptr] <= bus.push_len;
		end
	end

	//////////////////////////////
	// Pointers and fill count
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
		end
		else
		begin
			if (do_push)
				r_wr_ptr <= r_wr_ptr + 1'b1;
			if (do_pop)
				r_rd_ptr <= r_rd_ptr + 1'b1;

			// Simultaneous push and pop leaves the count alone
			if (do_push && !do_pop)
				r_count <= r_count + 1'b1;
			else if (do_pop && !do_push)
				r_count <= r_count - 1'b1;
		end
	end

	// Head of queue visible before the pop
	assign bus.pop_id  = mem_id[r_rd_ptr];
	assign bus.pop_len = mem_len[r_rd_ptr];

	// MSB of the count set only at DEPTH entries
	assign bus.full  = r_count[LG_FIFO_DEPTH];
	assign bus.empty = (r_count == '0);

endmodule

// File: design/burst_info_if.sv
// Burst info interface carrying burst ID and length from splitter to merger
interface burst_info_if
	import axi_bridge_pkg::*;
#(
	parameter int ID_WIDTH = 2
) ();

	// Push side gets one entry per accepted AXI request
	logic                push;
	logic [ID_WIDTH-1:0] push_id;
	burst_len_t          push_len;
	logic                full;

	// Pop side shows the head ahead of the pop
	logic                pop;
	logic [ID_WIDTH-1:0] pop_id;
	burst_len_t          pop_len;
	logic                empty;

	modport splitter
	(
		output push, push_id, push_len,
		input  full
	);

	modport fifo
	(
		input  push, push_id, push_len, pop,
		output full, pop_id, pop_len, empty
	);

	modport merger
	(
		output pop,
		input  pop_id, pop_len, empty
	);

endinterface

// File: design/r_burst_merger.sv
// R burst merger regrouping AXI-lite read beats into AXI bursts
module r_burst_merger
	import axi_bridge_pkg::*;
#(
	parameter int ID_WIDTH   = 2,
	parameter int DATA_WIDTH = 32
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,

	// Beats from the R skid buffer
	input  logic                  i_beat_valid,
	output logic                  o_beat_ready,
	input  logic [DATA_WIDTH-1:0] i_beat_data,
	input  axi_resp_t             i_beat_resp,

	// AXI read response
	output logic                  o_s_rvalid,
	input  logic                  i_s_rready,
	output logic [ID_WIDTH-1:0]   o_s_rid,
	output logic [DATA_WIDTH-1:0] o_s_rdata,
	output axi_resp_t             o_s_rresp,
	output logic                  o_s_rlast,

	burst_info_if.merger          info
);

	logic                  r_active;
	burst_len_t            r_left;
	logic [ID_WIDTH-1:0]   r_burst_id;
	logic                  r_rvalid;
	logic [ID_WIDTH-1:0]   r_rid;
	logic [DATA_WIDTH-1:0] r_rdata;
	axi_resp_t             r_rresp;
	logic                  r_rlast;
	logic                  out_free;
	logic                  beat_accept;
	logic                  first_beat;
	logic                  last_beat;

	//////////////////////////////
	// Beat acceptance
	//////////////////////////////

	// Output register empty or draining this cycle
	assign out_free = !r_rvalid || i_s_rready;

	// A new burst needs its info entry at the FIFO head
	assign o_beat_ready = out_free && (r_active || !info.empty);
	assign beat_accept  = i_beat_valid && o_beat_ready;
	assign first_beat   = !r_active;

	always_comb
	begin
		if (first_beat)
			last_beat = (info.pop_len == '0);
		else
			last_beat = (r_left == 8'd1);
	end

	// First beat of a burst retires the FIFO head
	assign info.pop = beat_accept && first_beat;

	//////////////////////////////
	// Burst tracking
	//////////////////////////////

	// r_left counts beats still due after the last accepted one
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_active <= 1'b0;
			r_left   <= '0;
		end
		else if (beat_accept)
		begin
			r_active <= !last_beat;
			if (first_beat)
				r_left <= info.pop_len;
			else
				r_left <= r_left - 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (info.pop)
			r_burst_id <= info.pop_id;
	end

	//////////////////////////////
	// Output stage
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_rvalid <= 1'b0;
		else if (beat_accept)
			r_rvalid <= 1'b1;
		else if (i_s_rready)
			r_rvalid <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (beat_accept)
		begin
			r_rid   <= first_beat ? info.pop_id : r_burst_id;
			r_rdata <= i_beat_data;
			r_rresp <= i_beat_resp;
			r_rlast <= last_beat;
		end
	end

	assign o_s_rvalid = r_rvalid;
	assign o_s_rid    = r_rid;
	assign o_s_rdata  = r_rdata;
	assign o_s_rresp  = r_rresp;
	assign o_s_rlast  = r_rlast;

endmodule

// File: verif/tb_axi2axilite_rd.sv
// Testbench for the AXI to AXI-lite read bridge with an AXI-lite slave model
module tb_axi2axilite_rd
	import axi_bridge_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          ID_WIDTH      = 2;
	localparam int          ADDR_WIDTH    = 12;
	localparam int          DATA_WIDTH    = 32;
	localparam int          LG_FIFO_DEPTH = 4;
	localparam logic [31:0] SEED          = 32'h5c5f96ff;
	localparam logic [31:0] DATA_PATTERN  = 32'ha5c3_0f96;
	// Slave answers SLVERR in [ERR_LO, ERR_HI)
	localparam logic [ADDR_WIDTH-1:0] ERR_LO = 12'h800;
	localparam logic [ADDR_WIDTH-1:0] ERR_HI = 12'h840;
	localparam int          TIMEOUT       = 200;

	logic                  S_AXI_ACLK;
	logic                  S_AXI_ARESETN;
	logic                  i_s_arvalid;
	logic                  o_s_arready;
	logic [ID_WIDTH-1:0]   i_s_arid;
	logic [ADDR_WIDTH-1:0] i_s_araddr;
	burst_len_t            i_s_arlen;
	burst_size_t           i_s_arsize;
	burst_type_t           i_s_arburst;
	logic                  o_s_rvalid;
	logic                  i_s_rready;
	logic [ID_WIDTH-1:0]   o_s_rid;
	logic [DATA_WIDTH-1:0] o_s_rdata;
	axi_resp_t             o_s_rresp;
	logic                  o_s_rlast;
	logic                  o_m_arvalid;
	logic                  i_m_arready;
	logic [ADDR_WIDTH-1:0] o_m_araddr;
	logic                  i_m_rvalid;
	logic                  o_m_rready;
	logic [DATA_WIDTH-1:0] i_m_rdata;
	axi_resp_t             i_m_rresp;

	// Expected beats and addresses and the addresses seen by the slave
	logic [ID_WIDTH-1:0]   exp_id[$];
	logic [DATA_WIDTH-1:0] exp_data[$];
	axi_resp_t             exp_resp[$];
	logic                  exp_last[$];
	logic [ADDR_WIDTH-1:0] exp_addr[$];
	logic [ADDR_WIDTH-1:0] ar_log[$];
	logic [ADDR_WIDTH-1:0] addr_q[$];

	logic [31:0] rdy_rng;
	int          errors;
	int          tests_run;
	int          tests_failed;

	axi2axilite_rd #(
		.ID_WIDTH      (ID_WIDTH),
		.ADDR_WIDTH    (ADDR_WIDTH),
		.DATA_WIDTH    (DATA_WIDTH),
		.LG_FIFO_DEPTH (LG_FIFO_DEPTH)
	) i_axi2axilite_rd (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_s_arvalid   (i_s_arvalid),
		.o_s_arready   (o_s_arready),
		.i_s_arid      (i_s_arid),
		.i_s_araddr    (i_s_araddr),
		.i_s_arlen     (i_s_arlen),
		.i_s_arsize    (i_s_arsize),
		.i_s_arburst   (i_s_arburst),
		.o_s_rvalid    (o_s_rvalid),
		.i_s_rready    (i_s_rready),
		.o_s_rid       (o_s_rid),
		.o_s_rdata     (o_s_rdata),
		.o_s_rresp     (o_s_rresp),
		.o_s_rlast     (o_s_rlast),
		.o_m_arvalid   (o_m_arvalid),
		.i_m_arready   (i_m_arready),
		.o_m_araddr    (o_m_araddr),
		.i_m_rvalid    (i_m_rvalid),
		.o_m_rready    (o_m_rready),
		.i_m_rdata     (i_m_rdata),
		.i_m_rresp     (i_m_rresp)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] read_data_for(input logic [ADDR_WIDTH-1:0] a);
		return {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, a} ^ DATA_PATTERN;
	endfunction

	function automatic logic in_err_window(input logic [ADDR_WIDTH-1:0] a);
		return (a >= ERR_LO) && (a < ERR_HI);
	endfunction

	//////////////////////////////
	// AXI-lite slave model
	//////////////////////////////

	initial
	begin : slave_model
		logic [31:0]           rng;
		logic [ADDR_WIDTH-1:0] a;
		int                    r_delay;
		logic                  active;
		logic                  ar_hs;
		logic                  r_hs;
		rng = SEED;
		r_delay = 0;
		forever
		begin
			@(posedge S_AXI_ACLK);
			// Reset state as seen at the clock edge
			active = S_AXI_ARESETN;
			ar_hs  = active && o_m_arvalid && i_m_arready;
			r_hs   = active && i_m_rvalid && o_m_rready;
			if (ar_hs)
			begin
				addr_q.push_back(o_m_araddr);
				ar_log.push_back(o_m_araddr);
			end
			#2;
			if (active)
			begin
				if (r_hs)
					i_m_rvalid = 1'b0;
				rng = xorshift32(rng);
				// Stall about one cycle in four
				i_m_arready = (rng[1:0] != 2'b00);
				if (!i_m_rvalid && addr_q.size() > 0)
				begin
					if (r_delay == 0)
					begin
						a = addr_q.pop_front();
						i_m_rvalid = 1'b1;
						i_m_rdata  = read_data_for(a);
						i_m_rresp  = in_err_window(a) ? RESP_SLVERR : RESP_OKAY;
						r_delay    = rng[5:4];
					end
					else
						r_delay--;
				end
			end
		end
	end

	//////////////////////////////
	// Driving and checking tasks
	//////////////////////////////

	task automatic clear_expected();
		exp_id.delete();
		exp_data.delete();
		exp_resp.delete();
		exp_last.delete();
		exp_addr.delete();
		ar_log.delete();
	endtask

	// WRAP steps like INCR in this bridge
	task automatic expect_burst(input logic [ID_WIDTH-1:0] id,
		input logic [ADDR_WIDTH-1:0] addr, input burst_len_t len,
		input burst_size_t size, input burst_type_t burst);
		logic [ADDR_WIDTH-1:0] a;
		a = addr;
		for (int i = 0; i <= len; i++)
		begin
			exp_addr.push_back(a);
			exp_id.push_back(id);
			exp_data.push_back(read_data_for(a));
			exp_resp.push_back(in_err_window(a) ? RESP_SLVERR : RESP_OKAY);
			exp_last.push_back(i == len);
			if (burst != BURST_FIXED)
				a = a + (1 << size);
		end
	endtask

	task automatic send_req(input logic [ID_WIDTH-1:0] id,
		input logic [ADDR_WIDTH-1:0] addr, input burst_len_t len,
		input burst_size_t size, input burst_type_t burst);
		int   cycles;
		logic done;
		cycles = 0;
		done   = 1'b0;
		i_s_arvalid = 1'b1;
		i_s_arid    = id;
		i_s_araddr  = addr;
		i_s_arlen   = len;
		i_s_arsize  = size;
		i_s_arburst = burst;
		while (!done && cycles < TIMEOUT)
		begin
			@(posedge S_AXI_ACLK);
			done = o_s_arready;
			cycles++;
		end
		#2;
		i_s_arvalid = 1'b0;
		if (!done)
		begin
			$display("Timeout: request with ID %0d was never accepted", id);
			errors++;
		end
	endtask

	task automatic check_beat();
		if (exp_id.size() == 0)
		begin
			$display("Unexpected R beat arrived with no beat left to expect");
			errors++;
		end
		else
		begin
			assert (o_s_rid === exp_id[0]) else
			begin
				$display("MISMATCH o_s_rid got %h expected %h", o_s_rid, exp_id[0]);
				errors++;
			end
			assert (o_s_rdata === exp_data[0]) else
			begin
				$display("MISMATCH o_s_rdata got %h expected %h", o_s_rdata, exp_data[0]);
				errors++;
			end
			assert (o_s_rresp === exp_resp[0]) else
			begin
				$display("MISMATCH o_s_rresp got %h expected %h", o_s_rresp, exp_resp[0]);
				errors++;
			end
			assert (o_s_rlast === exp_last[0]) else
			begin
				$display("MISMATCH o_s_rlast got %h expected %h", o_s_rlast, exp_last[0]);
				errors++;
			end
			void'(exp_id.pop_front());
			void'(exp_data.pop_front());
			void'(exp_resp.pop_front());
			void'(exp_last.pop_front());
		end
	endtask

	task automatic collect_beats(input int n, input logic random_ready);
		int got;
		int idle;
		got  = 0;
		idle = 0;
		while (got < n && idle < TIMEOUT)
		begin
			@(posedge S_AXI_ACLK);
			if (o_s_rvalid && i_s_rready)
			begin
				check_beat();
				got++;
				idle = 0;
			end
			else
				idle++;
			#2;
			rdy_rng = xorshift32(rdy_rng);
			i_s_rready = random_ready ? rdy_rng[0] : 1'b1;
		end
		i_s_rready = 1'b1;
		if (got < n)
		begin
			$display("Timeout: only %0d of %0d read beats arrived", got, n);
			errors++;
		end
	endtask

	task automatic check_addresses();
		assert (ar_log.size() == exp_addr.size()) else
		begin
			$display("Slave saw %0d addresses but %0d were expected",
				ar_log.size(), exp_addr.size());
			errors++;
		end
		for (int i = 0; i < ar_log.size() && i < exp_addr.size(); i++)
		begin
			assert (ar_log[i] === exp_addr[i]) else
			begin
				$display("MISMATCH o_m_araddr beat %0d got %h expected %h",
					i, ar_log[i], exp_addr[i]);
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("Test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_reset_values();
		int errors_before;
		errors_before = errors;
		assert (o_s_rvalid === 1'b0) else
		begin
			$display("MISMATCH o_s_rvalid got %h expected %h", o_s_rvalid, 1'b0);
			errors++;
		end
		assert (o_m_arvalid === 1'b0) else
		begin
			$display("MISMATCH o_m_arvalid got %h expected %h", o_m_arvalid, 1'b0);
			errors++;
		end
		assert (o_s_arready === 1'b1) else
		begin
			$display("MISMATCH o_s_arready got %h expected %h", o_s_arready, 1'b1);
			errors++;
		end
		report_test("reset values", errors_before);
	endtask

	task automatic test_single_beat();
		int errors_before;
		errors_before = errors;
		clear_expected();
		expect_burst(2'd1, 12'h230, 8'd0, 3'd2, BURST_INCR);
		fork
			send_req(2'd1, 12'h230, 8'd0, 3'd2, BURST_INCR);
			collect_beats(1, 1'b0);
		join
		check_addresses();
		report_test("single beat", errors_before);
	endtask

	// Start near the top so the addresses roll over
	task automatic test_incr_burst();
		int errors_before;
		errors_before = errors;
		clear_expected();
		expect_burst(2'd2, 12'hff0, 8'd7, 3'd2, BURST_INCR);
		fork
			send_req(2'd2, 12'hff0, 8'd7, 3'd2, BURST_INCR);
			collect_beats(8, 1'b0);
		join
		check_addresses();
		report_test("incr burst", errors_before);
	endtask

	task automatic test_fixed_burst();
		int errors_before;
		errors_before = errors;
		clear_expected();
		expect_burst(2'd3, 12'h124, 8'd3, 3'd2, BURST_FIXED);
		fork
			send_req(2'd3, 12'h124, 8'd3, 3'd2, BURST_FIXED);
			collect_beats(4, 1'b0);
		join
		check_addresses();
		report_test("fixed burst", errors_before);
	endtask

	// Second burst runs into the SLVERR window
	task automatic test_back_to_back();
		int errors_before;
		errors_before = errors;
		clear_expected();
		expect_burst(2'd1, 12'h100, 8'd2, 3'd2, BURST_INCR);
		expect_burst(2'd2, 12'h7f8, 8'd5, 3'd2, BURST_INCR);
		expect_burst(2'd3, 12'h200, 8'd0, 3'd2, BURST_INCR);
		expect_burst(2'd0, 12'h300, 8'd3, 3'd2, BURST_FIXED);
		fork
			begin
				send_req(2'd1, 12'h100, 8'd2, 3'd2, BURST_INCR);
				send_req(2'd2, 12'h7f8, 8'd5, 3'd2, BURST_INCR);
				send_req(2'd3, 12'h200, 8'd0, 3'd2, BURST_INCR);
				send_req(2'd0, 12'h300, 8'd3, 3'd2, BURST_FIXED);
			end
			collect_beats(14, 1'b1);
		join
		check_addresses();
		report_test("back to back", errors_before);
	endtask

	initial
	begin : main
		S_AXI_ARESETN = 1'b0;
		i_s_arvalid   = 1'b0;
		i_s_arid      = '0;
		i_s_araddr    = '0;
		i_s_arlen     = '0;
		i_s_arsize    = '0;
		i_s_arburst   = BURST_INCR;
		i_s_rready    = 1'b1;
		i_m_arready   = 1'b0;
		i_m_rvalid    = 1'b0;
		i_m_rdata     = '0;
		i_m_rresp     = RESP_OKAY;
		rdy_rng       = SEED;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (16) @(posedge S_AXI_ACLK);
		#2;
		S_AXI_ARESETN = 1'b1;
		test_reset_values();
		test_single_beat();
		test_incr_burst();
		test_fixed_burst();
		test_back_to_back();
		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
